// ==== Makefile ====
# Verilator build and run for the MSU register block

VERILATOR ?= verilator
TOP       ?= msu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/msu_patterns.txt ====
# Columns in hex: W addr data | R addr expected | B bufaddr data | A bufaddr
# F setmask clrmask | S status | P seek track volume | L volume latch pulse count
# Reset state and identification string
R 2000 C1
S 00
P 00000000 0000 00
R 2002 53
R 2003 2D
R 2004 4D
R 2005 53
R 2006 55
R 2007 31
# Seek address and track with start flags
W 2000 78
W 2001 56
W 2002 34
W 2003 12
S 10
W 2004 CD
W 2005 AB
P 12345678 ABCD 00
S 30
# Volume with a single latch strobe
W 2006 9A
P 12345678 ABCD 9A
L 1
S 30
# Data stream across stream address bit 13
B 1FFE 11
B 1FFF 22
B 2000 33
B 2001 44
A 1FFE
S 30
R 2001 11
R 2001 22
S 70
R 2001 33
R 2001 44
R 2008 44
S 70
# Flag masks, set then clear
F 0E 04
R 2000 D9
F 00 10
R 2000 59
S 60
F 02 0A
R 2000 41
# Audio control lock while audio busy
W 2007 05
S 60
F 00 20
R 2000 01
S 40
W 2007 05
S 4B
F 00 01
S 4A
W 2005 AB
S 6A
W 2007 02
S 6A
R 2000 41
L 1

// ==== bench/msu_props.sv ====
module msu_props (
  input logic                    clkin,
  input logic                    arst_n,
  input msu_pkg::msu_reg_e       reg_idx,
  input logic                    rd_pulse,
  input logic                    wr_pulse,
  input msu_pkg::msu_flag_bits_t flags_q,
  input msu_pkg::msu_status_t    status,
  input msu_pkg::msu_play_cmd_t  play_cmd
);
  timeunit 1ns;
  timeprecision 100ps;
  import msu_pkg::*;

  // Host interface pulses, seen where they enter the register block
  a_pulse_excl: assert property (
    @(posedge clkin) disable iff (!arst_n) !(rd_pulse && wr_pulse)
  ) else $error("rd_pulse and wr_pulse high in the same cycle");

  a_vol_single: assert property (
    @(posedge clkin) disable iff (!arst_n) play_cmd.vol_latch |=> !play_cmd.vol_latch
  ) else $error("volume latch high for two cycles in a row");

  // Control write during audio busy must leave the field alone
  a_ctrl_locked: assert property (
    @(posedge clkin) disable iff (!arst_n)
      (wr_pulse && reg_idx == REG_ACTRL_ID7 && flags_q.audio_busy)
      |=> $stable(status.audio_ctrl) && $stable(status.ctrl_start)
  ) else $error("audio control changed by a write while audio busy");

  a_ctrl_source: assert property (
    @(posedge clkin) disable iff (!arst_n)
      !$stable(status.audio_ctrl) |-> $past(wr_pulse && reg_idx == REG_ACTRL_ID7)
  ) else $error("audio control changed without a control register write");

endmodule

bind msu_regs msu_props u_props (
  .clkin    (clkin),
  .arst_n   (arst_n),
  .reg_idx  (reg_idx),
  .rd_pulse (rd_pulse),
  .wr_pulse (wr_pulse),
  .flags_q  (flags_q),
  .status   (status),
  .play_cmd (play_cmd)
);

// ==== bench/msu_tb.sv ====
module msu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import msu_pkg::*;

  localparam int BUF_AW   = 14;
  localparam int MAX_WAIT = 64;

  logic              clkin;
  logic              arst_n;
  logic [15:0]       bus_addr;
  logic [7:0]        bus_wdata;
  logic              bus_rd_n;
  logic              bus_wr_n;
  logic [7:0]        bus_rdata;
  logic [BUF_AW-1:0] pgm_addr;
  logic [7:0]        pgm_data;
  logic              pgm_we;
  logic              buf_addr_load;
  logic [BUF_AW-1:0] buf_addr_val;
  logic              flag_we;
  msu_flag_bits_t    flag_set;
  msu_flag_bits_t    flag_clr;
  msu_status_t       status;
  msu_play_cmd_t     play_cmd;

  int errors;
  int checks;
  int latch_count;

  msu_top #(
    .BASE_ADDR (16'h2000),
    .BUF_AW    (BUF_AW)
  ) u_msu_top (.*);

  initial begin
    clkin = 1'b0;
    forever #2 clkin = ~clkin;
  end

  // Volume latch strobes, sampled away from the rising edge
  always @(negedge clkin) begin
    if (arst_n && play_cmd.vol_latch) begin
      latch_count++;
    end
  end

  initial begin
    #100us;
    $display("Watchdog expired before the pattern file was done");
    $display("SIMULATION FAILED");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Cycle helpers
  //////////////////////////////////////////////////////////////////////

  // Ends 1 ns after the last counted edge
  task automatic wait_cycles(input int n);
    int cnt;
    cnt = 0;
    while (cnt < n && cnt < MAX_WAIT) begin
      @(posedge clkin);
      cnt++;
    end
    if (cnt < n) begin
      $display("Wait of %0d cycles stopped at the limit, time %0t", n, $time);
      errors++;
    end
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Console and microcontroller accesses
  //////////////////////////////////////////////////////////////////////
  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    bus_addr  = addr;
    bus_wdata = data;
    bus_wr_n  = 1'b0;
    wait_cycles(6);
    bus_wr_n = 1'b1;
    // Registers follow 4 cycles after the rising strobe
    wait_cycles(6);
  endtask

  task automatic bus_read(input logic [15:0] addr, input logic [7:0] exp);
    bus_addr = addr;
    bus_rd_n = 1'b0;
    // Fixed read latency from the falling strobe
    wait_cycles(4);
    checks++;
    if (bus_rdata !== exp) begin
      report_mismatch("bus_rdata", 32'(bus_rdata), 32'(exp));
    end
    wait_cycles(2);
    bus_rd_n = 1'b1;
    wait_cycles(4);
  endtask

  task automatic buf_program(input logic [BUF_AW-1:0] addr, input logic [7:0] data);
    pgm_addr = addr;
    pgm_data = data;
    pgm_we   = 1'b1;
    wait_cycles(1);
    pgm_we = 1'b0;
    wait_cycles(1);
  endtask

  task automatic stream_load(input logic [BUF_AW-1:0] val);
    buf_addr_val  = val;
    buf_addr_load = 1'b1;
    wait_cycles(3);
    buf_addr_load = 1'b0;
    wait_cycles(4);
  endtask

  task automatic flag_update(input logic [5:0] set_mask, input logic [5:0] clr_mask);
    flag_set = set_mask;
    flag_clr = clr_mask;
    flag_we  = 1'b1;
    wait_cycles(3);
    flag_we = 1'b0;
    wait_cycles(4);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Pattern file sequencer
  //////////////////////////////////////////////////////////////////////
  initial begin
    int          fd;
    int          n;
    int          ch;
    int          want;
    int          got_ops;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    msu_status_t exp_status;

    errors        = 0;
    checks        = 0;
    latch_count   = 0;
    arst_n        = 1'b0;
    bus_addr      = '0;
    bus_wdata     = '0;
    bus_rd_n      = 1'b1;
    bus_wr_n      = 1'b1;
    pgm_addr      = '0;
    pgm_data      = '0;
    pgm_we        = 1'b0;
    buf_addr_load = 1'b0;
    buf_addr_val  = '0;
    flag_we       = 1'b0;
    flag_set      = '0;
    flag_clr      = '0;
    wait_cycles(16);
    arst_n = 1'b1;
    wait_cycles(4);

    fd = $fopen("bench/msu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open bench/msu_patterns.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fscanf(fd, " %c", op);
        if (n == 1) begin
          want    = 2;
          got_ops = 0;
          case (op)
            "#": begin
              want = 0;
              ch   = 0;
              while (ch != 10 && ch != -1) begin
                ch = $fgetc(fd);
              end
            end
            "W": begin
              got_ops = $fscanf(fd, "%h %h", a, b);
              bus_write(a[15:0], b[7:0]);
            end
            "R": begin
              got_ops = $fscanf(fd, "%h %h", a, b);
              bus_read(a[15:0], b[7:0]);
            end
            "B": begin
              got_ops = $fscanf(fd, "%h %h", a, b);
              buf_program(a[BUF_AW-1:0], b[7:0]);
            end
            "A": begin
              want    = 1;
              got_ops = $fscanf(fd, "%h", a);
              stream_load(a[BUF_AW-1:0]);
            end
            "F": begin
              got_ops = $fscanf(fd, "%h %h", a, b);
              flag_update(a[5:0], b[5:0]);
            end
            "S": begin
              want    = 1;
              got_ops = $fscanf(fd, "%h", a);
              // Pattern value leaves out the volume latch, idle between accesses
              exp_status = {a[6:4], 1'b0, a[3:0]};
              checks++;
              if (status !== exp_status) begin
                report_mismatch("status", 32'(status), 32'(exp_status));
              end
            end
            "P": begin
              want    = 3;
              got_ops = $fscanf(fd, "%h %h %h", a, b, c);
              checks += 3;
              if (play_cmd.seek_addr !== a) begin
                report_mismatch("play_cmd.seek_addr", play_cmd.seek_addr, a);
              end
              if (play_cmd.track !== b[15:0]) begin
                report_mismatch("play_cmd.track", 32'(play_cmd.track), b);
              end
              if (play_cmd.volume !== c[7:0]) begin
                report_mismatch("play_cmd.volume", 32'(play_cmd.volume), c);
              end
            end
            "L": begin
              want    = 1;
              got_ops = $fscanf(fd, "%h", a);
              checks++;
              if (latch_count != int'(a)) begin
                report_mismatch("vol_latch pulse count", 32'(latch_count), a);
              end
            end
            default: begin
              want = 0;
              $display("Unknown opcode '%c' in the pattern file", op);
              errors++;
            end
          endcase
          if (got_ops != want) begin
            $display("Pattern line for opcode '%c' has missing operands", op);
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    wait_cycles(8);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
rtl/msu_pkg.sv
rtl/msu_host_if.sv
rtl/msu_databuf.sv
rtl/msu_regs.sv
rtl/msu_top.sv
bench/msu_props.sv
bench/msu_tb.sv

// ==== rtl/msu_databuf.sv ====
module msu_databuf #(
  parameter int BUF_AW = 14
) (
  input  logic              clkin,
  input  logic              wr_en,
  input  logic [BUF_AW-1:0] wr_addr,
  input  logic [7:0]        wr_data,
  input  logic [BUF_AW-1:0] rd_addr,
  output logic [7:0]        rd_data
);

  localparam int DEPTH = 2 ** BUF_AW;

  logic [7:0] mem [DEPTH];

  // Microcontroller fill port
  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Stream read port, one cycle latency
  always_ff @(posedge clkin) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== rtl/msu_host_if.sv ====
module msu_host_if #(
  parameter logic [15:0] BASE_ADDR = 16'h2000
) (
  input  logic               clkin,
  input  logic               arst_n,
  input  logic [15:0]        bus_addr,
  input  logic [7:0]         bus_wdata,
  input  logic               bus_rd_n,
  input  logic               bus_wr_n,
  output msu_pkg::msu_reg_e  reg_idx,
  output logic [7:0]         reg_wdata,
  output logic               rd_pulse,
  output logic               wr_pulse
);
  import msu_pkg::*;

  // Strobe vectors hold {rd_n, wr_n}
  logic [1:0]     strb_meta;
  logic [1:0]     strb_sync;
  logic [1:0]     strb_prev;
  logic           rd_low;
  logic           wr_low;
  logic           rd_fall;
  logic           wr_fall;
  logic           wr_rise;
  logic           in_window;
  logic           acc_start;
  logic           hit_q;
  msu_bus_phase_e phase_q;
  msu_bus_phase_e phase_d;

  //////////////////////////////////////////////////////////////////////
  // Strobe synchronizer and edge register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      strb_meta <= 2'b11;
      strb_sync <= 2'b11;
      strb_prev <= 2'b11;
    end else begin
      strb_meta <= {bus_rd_n, bus_wr_n};
      strb_sync <= strb_meta;
      strb_prev <= strb_sync;
    end
  end

  assign rd_low  = ~strb_sync[1];
  assign wr_low  = ~strb_sync[0];
  assign rd_fall = strb_prev[1] & ~strb_sync[1];
  assign wr_fall = strb_prev[0] & ~strb_sync[0];
  assign wr_rise = ~strb_prev[0] & strb_sync[0];

  // Eight byte window at BASE_ADDR
  assign in_window = (bus_addr[15:3] == BASE_ADDR[15:3]);

  //////////////////////////////////////////////////////////////////////
  // Bus phase FSM
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    phase_d = phase_q;
    unique case (phase_q)
      BUS_IDLE: begin
        // Both strobes falling together is rejected
        if (rd_fall && !wr_low) begin
          phase_d = BUS_READ;
        end else if (wr_fall && !rd_low) begin
          phase_d = BUS_WRITE;
        end
      end
      BUS_READ: begin
        if (!rd_low) begin
          phase_d = BUS_IDLE;
        end
      end
      BUS_WRITE: begin
        // A read strobe during the write aborts it
        if (!wr_low || rd_low) begin
          phase_d = BUS_IDLE;
        end
      end
      default: phase_d = BUS_IDLE;
    endcase
  end

  assign acc_start = (phase_q == BUS_IDLE) && (phase_d != BUS_IDLE);

  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      phase_q  <= BUS_IDLE;
      hit_q    <= 1'b0;
      rd_pulse <= 1'b0;
      wr_pulse <= 1'b0;
    end else begin
      phase_q  <= phase_d;
      if (acc_start) begin
        hit_q <= in_window;
      end
      rd_pulse <= acc_start && (phase_d == BUS_READ) && in_window;
      wr_pulse <= (phase_q == BUS_WRITE) && wr_rise && !rd_low && hit_q;
    end
  end

  // Address and data taken once, when the access starts
  always_ff @(posedge clkin) begin
    if (acc_start) begin
      reg_idx   <= msu_reg_e'(bus_addr[2:0]);
      reg_wdata <= bus_wdata;
    end
  end

endmodule

// ==== rtl/msu_pkg.sv ====
package msu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register window
  //////////////////////////////////////////////////////////////////////

  // Each name gives the write meaning first, then the read meaning
  typedef enum logic [2:0] {
    REG_SEEK0_STAT = 3'd0,
    REG_SEEK1_DATA = 3'd1,
    REG_SEEK2_ID2  = 3'd2,
    REG_SEEK3_ID3  = 3'd3,
    REG_TRKLO_ID4  = 3'd4,
    REG_TRKHI_ID5  = 3'd5,
    REG_VOL_ID6    = 3'd6,
    REG_ACTRL_ID7  = 3'd7
  } msu_reg_e;

  // Console bus access in progress
  typedef enum logic [1:0] {
    BUS_IDLE  = 2'd0,
    BUS_READ  = 2'd1,
    BUS_WRITE = 2'd2
  } msu_bus_phase_e;

  //////////////////////////////////////////////////////////////////////
  // Microcontroller side
  //////////////////////////////////////////////////////////////////////

  // Status word, MSB first
  typedef struct packed {
    logic       stream_hi;
    logic       audio_start;
    logic       data_start;
    logic       vol_latch;
    logic [2:0] audio_ctrl;
    logic       ctrl_start;
  } msu_status_t;

  // Playback command towards SD and audio engine
  typedef struct packed {
    logic [31:0] seek_addr;
    logic [15:0] track;
    logic [7:0]  volume;
    logic        vol_latch;
  } msu_play_cmd_t;

  // Set and clear masks, same layout as the flag register
  typedef struct packed {
    logic       audio_busy;
    logic       data_busy;
    logic       audio_error;
    logic [1:0] audio_status;
    logic       ctrl_start;
  } msu_flag_bits_t;

  // Returned by read registers 2 to 7, element 0 first
  localparam logic [0:5][7:0] MSU_ID_STRING = "S-MSU1";

endpackage

// ==== rtl/msu_regs.sv ====
module msu_regs #(
  parameter int BUF_AW = 14
) (
  input  logic                    clkin,
  input  logic                    arst_n,
  input  msu_pkg::msu_reg_e       reg_idx,
  input  logic [7:0]              reg_wdata,
  input  logic                    rd_pulse,
  input  logic                    wr_pulse,
  output logic [7:0]              rdata,
  output logic [BUF_AW-1:0]       stream_addr,
  input  logic [7:0]              buf_rdata,
  input  logic                    buf_addr_load,
  input  logic [BUF_AW-1:0]       buf_addr_val,
  input  logic                    flag_we,
  input  msu_pkg::msu_flag_bits_t flag_set,
  input  msu_pkg::msu_flag_bits_t flag_clr,
  output msu_pkg::msu_status_t    status,
  output msu_pkg::msu_play_cmd_t  play_cmd
);
  import msu_pkg::*;

  localparam logic [2:0] MSU_REVISION = 3'b001;

  // Microcontroller strobe history, bit 1 flag_we and bit 0 buf_addr_load
  logic [2:0][1:0] mcu_sr;
  logic            load_rise;
  logic            flag_rise;
  logic            data_rd;

  msu_play_cmd_t   cmd_q;
  msu_flag_bits_t  flags_q;
  logic            audio_start;
  logic            data_start;
  logic [2:0]      audio_ctrl;

  //////////////////////////////////////////////////////////////////////
  // Microcontroller strobe edges
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      mcu_sr <= '0;
    end else begin
      mcu_sr <= {mcu_sr[1:0], flag_we, buf_addr_load};
    end
  end

  assign load_rise = mcu_sr[1][0] & ~mcu_sr[2][0];
  assign flag_rise = mcu_sr[1][1] & ~mcu_sr[2][1];

  //////////////////////////////////////////////////////////////////////
  // Data stream address
  //////////////////////////////////////////////////////////////////////
  assign data_rd = rd_pulse && (reg_idx == REG_SEEK1_DATA);

  // Reload beats the read increment
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      stream_addr <= '0;
    end else if (load_rise) begin
      stream_addr <= buf_addr_val;
    end else if (data_rd) begin
      stream_addr <= stream_addr + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else if (rd_pulse) begin
      unique case (reg_idx)
        REG_SEEK0_STAT: begin
          rdata <= {flags_q.data_busy, flags_q.audio_busy, flags_q.audio_status,
                    flags_q.audio_error, MSU_REVISION};
        end
        // Buffer output already holds the byte at stream_addr
        REG_SEEK1_DATA: rdata <= buf_rdata;
        REG_SEEK2_ID2:  rdata <= MSU_ID_STRING[0];
        REG_SEEK3_ID3:  rdata <= MSU_ID_STRING[1];
        REG_TRKLO_ID4:  rdata <= MSU_ID_STRING[2];
        REG_TRKHI_ID5:  rdata <= MSU_ID_STRING[3];
        REG_VOL_ID6:    rdata <= MSU_ID_STRING[4];
        REG_ACTRL_ID7:  rdata <= MSU_ID_STRING[5];
        default:        rdata <= '0;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command registers and status flags
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clkin or negedge arst_n) begin
    if (!arst_n) begin
      cmd_q       <= '0;
      flags_q     <= '{audio_busy: 1'b1, data_busy: 1'b1, default: '0};
      audio_start <= 1'b0;
      data_start  <= 1'b0;
      audio_ctrl  <= '0;
    end else begin
      // Volume latch is a single cycle strobe
      cmd_q.vol_latch <= 1'b0;
      if (wr_pulse) begin
        unique case (reg_idx)
          REG_SEEK0_STAT: cmd_q.seek_addr[7:0]   <= reg_wdata;
          REG_SEEK1_DATA: cmd_q.seek_addr[15:8]  <= reg_wdata;
          REG_SEEK2_ID2:  cmd_q.seek_addr[23:16] <= reg_wdata;
          REG_SEEK3_ID3: begin
            // Top seek byte kicks off the data transfer
            cmd_q.seek_addr[31:24] <= reg_wdata;
            data_start             <= 1'b1;
            flags_q.data_busy      <= 1'b1;
          end
          REG_TRKLO_ID4:  cmd_q.track[7:0] <= reg_wdata;
          REG_TRKHI_ID5: begin
            cmd_q.track[15:8]  <= reg_wdata;
            audio_start        <= 1'b1;
            flags_q.audio_busy <= 1'b1;
          end
          REG_VOL_ID6: begin
            cmd_q.volume    <= reg_wdata;
            cmd_q.vol_latch <= 1'b1;
          end
          REG_ACTRL_ID7: begin
            // Locked while a track is being prepared
            if (!flags_q.audio_busy) begin
              audio_ctrl         <= reg_wdata[2:0];
              flags_q.ctrl_start <= 1'b1;
            end
          end
          default: ;
        endcase
      end else if (flag_rise) begin
        // Set first, clear wins
        flags_q <= (flags_q | flag_set) & ~flag_clr;
        if (flag_clr.audio_busy) begin
          audio_start <= 1'b0;
        end
        if (flag_clr.data_busy) begin
          data_start <= 1'b0;
        end
      end
    end
  end

  assign status = '{
    stream_hi:   stream_addr[BUF_AW-1],
    audio_start: audio_start,
    data_start:  data_start,
    vol_latch:   cmd_q.vol_latch,
    audio_ctrl:  audio_ctrl,
    ctrl_start:  flags_q.ctrl_start
  };

  assign play_cmd = cmd_q;

endmodule

// ==== rtl/msu_top.sv ====
module msu_top #(
  parameter logic [15:0] BASE_ADDR = 16'h2000,
  parameter int          BUF_AW    = 14
) (
  input  logic                    clkin,
  input  logic                    arst_n,
  // Console bus
  input  logic [15:0]             bus_addr,
  input  logic [7:0]              bus_wdata,
  input  logic                    bus_rd_n,
  input  logic                    bus_wr_n,
  output logic [7:0]              bus_rdata,
  // Microcontroller side
  input  logic [BUF_AW-1:0]       pgm_addr,
  input  logic [7:0]              pgm_data,
  input  logic                    pgm_we,
  input  logic                    buf_addr_load,
  input  logic [BUF_AW-1:0]       buf_addr_val,
  input  logic                    flag_we,
  input  msu_pkg::msu_flag_bits_t flag_set,
  input  msu_pkg::msu_flag_bits_t flag_clr,
  output msu_pkg::msu_status_t    status,
  output msu_pkg::msu_play_cmd_t  play_cmd
);
  import msu_pkg::*;

  msu_reg_e          reg_idx;
  logic [7:0]        reg_wdata;
  logic              rd_pulse;
  logic              wr_pulse;
  logic [BUF_AW-1:0] stream_addr;
  logic [7:0]        buf_rdata;

  msu_host_if #(
    .BASE_ADDR (BASE_ADDR)
  ) u_host_if (
    .clkin     (clkin),
    .arst_n    (arst_n),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rd_n  (bus_rd_n),
    .bus_wr_n  (bus_wr_n),
    .reg_idx   (reg_idx),
    .reg_wdata (reg_wdata),
    .rd_pulse  (rd_pulse),
    .wr_pulse  (wr_pulse)
  );

  msu_regs #(
    .BUF_AW (BUF_AW)
  ) u_regs (
    .clkin         (clkin),
    .arst_n        (arst_n),
    .reg_idx       (reg_idx),
    .reg_wdata     (reg_wdata),
    .rd_pulse      (rd_pulse),
    .wr_pulse      (wr_pulse),
    .rdata         (bus_rdata),
    .stream_addr   (stream_addr),
    .buf_rdata     (buf_rdata),
    .buf_addr_load (buf_addr_load),
    .buf_addr_val  (buf_addr_val),
    .flag_we       (flag_we),
    .flag_set      (flag_set),
    .flag_clr      (flag_clr),
    .status        (status),
    .play_cmd      (play_cmd)
  );

  msu_databuf #(
    .BUF_AW (BUF_AW)
  ) u_databuf (
    .clkin   (clkin),
    .wr_en   (pgm_we),
    .wr_addr (pgm_addr),
    .wr_data (pgm_data),
    .rd_addr (stream_addr),
    .rd_data (buf_rdata)
  );

endmodule
